/* Bender.yml */
package:
  name: cpu6502_lite

sources:
  - files:
      - design/cpu_pkg.sv
      - design/cpu_decode.sv
      - design/cpu_alu.sv
      - design/cpu_regfile.sv
      - design/cpu_sequencer.sv
      - design/cpu_top.sv
  - target: simulation
    files:
      - verification/cpu_tb.sv

# Simulation top is cpu_tb, synthesis top is cpu_top

/* design/cpu_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_alu import cpu_pkg::*; (
    input  logic [DATA_W-1:0] operand_a,
    input  logic [DATA_W-1:0] operand_b,
    input  alu_op_t           op,
    input  logic [DATA_W-1:0] flags_in,
    output logic [DATA_W-1:0] result,
    output logic [DATA_W-1:0] flags_out
);

    logic              subtract;  // SBC and CMP invert B
    logic [DATA_W-1:0] b_eff;
    logic              carry_in;
    logic [DATA_W:0]   sum;       // Carry out in the top bit

    // Shared adder
    // --------------------
    assign subtract = (op == ALU_SBC) || (op == ALU_CMP);
    assign b_eff    = subtract ? ~operand_b : operand_b;
    assign carry_in = (op == ALU_CMP) ? 1'b1 : flags_in[FLAG_C];  // CMP ignores C
    assign sum      = operand_a + b_eff + carry_in;

    always_comb begin
        result    = operand_b;
        flags_out = flags_in;
        case (op)
            ALU_ORA: result = operand_a | operand_b;
            ALU_AND: result = operand_a & operand_b;
            ALU_EOR: result = operand_a ^ operand_b;
            ALU_ADC,
            ALU_SBC: begin
                result            = sum[DATA_W-1:0];
                flags_out[FLAG_C] = sum[DATA_W];
                // Same input signs, result sign differs
                flags_out[FLAG_V] = (operand_a[DATA_W-1] == b_eff[DATA_W-1]) &&
                                    (sum[DATA_W-1] != operand_a[DATA_W-1]);
            end
            ALU_CMP: begin
                result            = sum[DATA_W-1:0];  // Difference for N, Z only
                flags_out[FLAG_C] = sum[DATA_W];      // No borrow
            end
            ALU_CLC: flags_out[FLAG_C] = 1'b0;
            ALU_SEC: flags_out[FLAG_C] = 1'b1;
            ALU_CLV: flags_out[FLAG_V] = 1'b0;
            default: result = operand_b;  // Pass
        endcase

        // N and Z track the result
        if (!(op inside {ALU_CLC, ALU_SEC, ALU_CLV})) begin
            flags_out[FLAG_N] = result[DATA_W-1];
            flags_out[FLAG_Z] = (result == '0);
        end
    end

endmodule

`default_nettype wire

/* design/cpu_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_decode import cpu_pkg::*; (
    input  logic [DATA_W-1:0] opcode,
    input  logic [DATA_W-1:0] flags,
    output addr_mode_t        mode,
    output alu_op_t           alu_op,
    output reg_sel_t          dst_sel,
    output reg_sel_t          src_sel,
    output logic              operand_from_reg,
    output logic              reg_write,
    output logic              flag_write,
    output logic              is_store,
    output reg_sel_t          index_sel,
    output logic              branch_taken
);

    logic flag_bit;  // P bit tested by a branch

    // Addressing mode from aaa_bbb_cc
    // --------------------
    always_comb begin
        casez (opcode)
            8'b100_010_01: mode = MODE_IMPL;  // No STA immediate
            8'b???_001_01: mode = MODE_ZP;
            8'b???_010_01: mode = MODE_IMM;
            8'b???_011_01: mode = MODE_ABS;
            8'b???_110_01: mode = MODE_ABY;
            8'b???_111_01: mode = MODE_ABX;
            8'b101_000_10: mode = MODE_IMM;   // LDX #
            8'b10?_001_10: mode = MODE_ZP;    // STX, LDX
            8'b10?_011_10: mode = MODE_ABS;
            8'b101_111_10: mode = MODE_ABY;   // LDX abs,Y
            8'b101_000_00,
            8'b11?_000_00: mode = MODE_IMM;   // LDY, CPY, CPX #
            8'b1??_001_00: mode = MODE_ZP;    // STY, LDY, CPY, CPX
            8'b1??_011_00: mode = MODE_ABS;
            8'b101_111_00: mode = MODE_ABX;   // LDY abs,X
            8'b010_011_00: mode = MODE_JMP;
            8'b???_100_00: mode = MODE_REL;   // Bcc
            default:       mode = MODE_IMPL;  // Everything else is a NOP
        endcase
    end

    // Execution controls
    // --------------------
    always_comb begin
        alu_op           = ALU_PASS;
        dst_sel          = REG_A;
        src_sel          = REG_A;
        reg_write        = 1'b0;
        flag_write       = 1'b0;
        is_store         = 1'b0;
        operand_from_reg = (mode == MODE_IMPL);  // Keep ALU off the bus
        index_sel        = (mode == MODE_ABY) ? REG_Y : REG_X;

        if (mode inside {MODE_IMM, MODE_ZP, MODE_ABS, MODE_ABX, MODE_ABY}) begin
            is_store = (opcode[7:5] == 3'b100);
            if (opcode[1:0] == 2'b01) begin
                // Accumulator group
                case (opcode[7:5])
                    3'b000:  alu_op = ALU_ORA;
                    3'b001:  alu_op = ALU_AND;
                    3'b010:  alu_op = ALU_EOR;
                    3'b011:  alu_op = ALU_ADC;
                    3'b110:  alu_op = ALU_CMP;
                    3'b111:  alu_op = ALU_SBC;
                    default: alu_op = ALU_PASS;  // STA, LDA
                endcase
                reg_write  = !(is_store || opcode[7:5] == 3'b110);
                flag_write = !is_store;
            end else begin
                // Index group with X for cc=10 and CPX
                dst_sel    = (opcode[1] || opcode[7:5] == 3'b111) ? REG_X : REG_Y;
                src_sel    = dst_sel;
                alu_op     = opcode[6] ? ALU_CMP : ALU_PASS;
                reg_write  = (opcode[7:5] == 3'b101);  // LDX, LDY
                flag_write = !is_store;
            end
        end else if (mode == MODE_IMPL && opcode[4:0] == 5'b110_00) begin
            case (opcode[7:5])
                3'b000: begin
                    alu_op     = ALU_CLC;
                    flag_write = 1'b1;
                end
                3'b001: begin
                    alu_op     = ALU_SEC;
                    flag_write = 1'b1;
                end
                3'b101: begin
                    alu_op     = ALU_CLV;
                    flag_write = 1'b1;
                end
                default: flag_write = 1'b0;  // CLI, SEI, CLD, SED ignored
            endcase
        end
    end

    // Branch condition from the flag that bits 7:6 pick
    always_comb begin
        case (opcode[7:6])
            2'b00:   flag_bit = flags[FLAG_N];
            2'b01:   flag_bit = flags[FLAG_V];
            2'b10:   flag_bit = flags[FLAG_C];
            default: flag_bit = flags[FLAG_Z];
        endcase
        branch_taken = (mode == MODE_REL) && (flag_bit == opcode[5]);
    end

endmodule

`default_nettype wire

/* design/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    // Bus widths
    // --------------------
    localparam int DATA_W = 8;   // Registers and data bus
    localparam int ADDR_W = 16;  // Address bus

    // Sequencer cycles
    // --------------------
    typedef enum logic [4:0] {
        FETCH,     // Opcode read, PC++
        IMM_EXEC,  // Immediate or implied execute
        ZP_ADDR,   // Zero page address byte
        ABS_LO,    // Absolute low byte
        ABS_HI,    // Absolute high byte, JMP lands here
        IDX_LO,    // Indexed low byte plus index
        IDX_HI,    // Indexed high byte plus carry
        IDX_FIX,   // Extra cycle for carry or store
        EXEC,      // Memory operand cycle
        BR_EVAL,   // Branch offset and condition
        BR_SAME,   // Taken, same page
        BR_CROSS,  // Taken, page crossed
        RST_LO,    // Reset vector low byte
        RST_HI     // Reset vector high byte
    } cpu_state_t;

    // Addressing modes
    typedef enum logic [2:0] {
        MODE_IMPL,
        MODE_IMM,
        MODE_ZP,
        MODE_ABS,
        MODE_ABX,
        MODE_ABY,
        MODE_REL,
        MODE_JMP
    } addr_mode_t;

    // ALU operations
    // --------------------
    typedef enum logic [3:0] {
        ALU_ORA,
        ALU_AND,
        ALU_EOR,
        ALU_ADC,
        ALU_PASS,  // LDA, LDX, LDY, stores
        ALU_CMP,   // CMP, CPX, CPY
        ALU_SBC,
        ALU_CLC,
        ALU_SEC,
        ALU_CLV
    } alu_op_t;

    // Register names, code 3 unused
    typedef enum logic [1:0] {
        REG_A,
        REG_X,
        REG_Y
    } reg_sel_t;

    // Bit positions in P
    localparam int FLAG_N = 7;
    localparam int FLAG_V = 6;
    localparam int FLAG_Z = 1;
    localparam int FLAG_C = 0;

endpackage

`default_nettype wire

/* design/cpu_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_regfile import cpu_pkg::*; (
    input  logic              CLK,
    input  logic              RESET,
    input  logic [DATA_W-1:0] din,
    input  logic              exec_strobe,
    input  reg_sel_t          dst_sel,
    input  reg_sel_t          src_sel,
    input  reg_sel_t          index_sel,
    input  logic              operand_from_reg,
    input  logic              reg_write,
    input  logic              flag_write,
    input  logic [DATA_W-1:0] alu_result,
    input  logic [DATA_W-1:0] alu_flags,
    output logic [DATA_W-1:0] operand_a,
    output logic [DATA_W-1:0] operand_b,
    output logic [DATA_W-1:0] index,
    output logic [DATA_W-1:0] store_data,
    output logic [DATA_W-1:0] flags
);

    logic [DATA_W-1:0] reg_a;
    logic [DATA_W-1:0] reg_x;
    logic [DATA_W-1:0] reg_y;
    logic [DATA_W-1:0] reg_p;

    function automatic logic [DATA_W-1:0] pick(input reg_sel_t sel, input logic [DATA_W-1:0] a,
                                               input logic [DATA_W-1:0] x,
                                               input logic [DATA_W-1:0] y);
        case (sel)
            REG_X:   return x;
            REG_Y:   return y;
            default: return a;
        endcase
    endfunction

    // Operand paths
    // --------------------
    assign operand_a  = pick(dst_sel, reg_a, reg_x, reg_y);      // Accumulating register
    assign store_data = pick(src_sel, reg_a, reg_x, reg_y);      // STA, STX, STY source
    assign operand_b  = operand_from_reg ? store_data : din;     // Memory or immediate
    assign index      = pick(index_sel, reg_a, reg_x, reg_y);
    assign flags      = reg_p;

    // Write-back at the end of EXEC or IMM_EXEC
    always_ff @(posedge CLK) begin
        if (RESET) begin
            reg_a <= '0;
            reg_x <= '0;
            reg_y <= '0;
            reg_p <= '0;
        end else if (exec_strobe) begin
            if (reg_write) begin
                case (dst_sel)
                    REG_X:   reg_x <= alu_result;
                    REG_Y:   reg_y <= alu_result;
                    default: reg_a <= alu_result;
                endcase
            end
            if (flag_write) reg_p <= alu_flags;
        end
    end

    dst_legal: assert property (@(posedge CLK) disable iff (RESET)
        exec_strobe && reg_write |-> dst_sel inside {REG_A, REG_X, REG_Y});

endmodule

`default_nettype wire

/* design/cpu_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_sequencer import cpu_pkg::*; #(
    parameter logic [ADDR_W-1:0] RESET_VECTOR = 16'hFFFC
) (
    input  logic              CLK,
    input  logic              RESET,
    input  logic [DATA_W-1:0] din,
    input  addr_mode_t        mode,
    input  logic              is_store,
    input  logic [DATA_W-1:0] index,
    input  logic [DATA_W-1:0] store_data,
    input  logic              branch_taken,
    output logic [DATA_W-1:0] opcode,
    output logic              exec_strobe,
    output logic [ADDR_W-1:0] addr,
    output logic [ADDR_W-1:0] eawr,
    output logic [DATA_W-1:0] dout,
    output logic              wreq
);

    cpu_state_t        state;
    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] ea;         // Effective address
    logic [DATA_W-1:0] tr;         // Low byte holding register
    logic              carry;      // Page carry from the index add
    logic [DATA_W-1:0] opcode_r;
    logic [ADDR_W-1:0] pc_inc;
    logic [ADDR_W-1:0] br_target;
    logic              same_page;
    logic [DATA_W:0]   idx_sum;

    // Address and helpers
    // --------------------
    assign opcode      = (state == FETCH) ? din : opcode_r;  // Decode in the fetch cycle
    assign addr        = (state == EXEC || state == IDX_FIX) ? ea : pc;
    assign eawr        = ea;
    assign exec_strobe = (state == EXEC) || (state == IMM_EXEC);
    assign pc_inc      = pc + 1'b1;
    assign br_target   = pc_inc + {{(ADDR_W-DATA_W){din[DATA_W-1]}}, din};  // Signed offset
    assign same_page   = (br_target[ADDR_W-1:DATA_W] == pc_inc[ADDR_W-1:DATA_W]);
    assign idx_sum     = din + index;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state <= RST_LO;
            pc    <= RESET_VECTOR;
            wreq  <= 1'b0;
        end else begin
            wreq <= 1'b0;  // One-cycle store level
            case (state)
                FETCH: begin
                    opcode_r <= din;
                    pc       <= pc_inc;
                    case (mode)
                        MODE_IMPL,
                        MODE_IMM: state <= IMM_EXEC;
                        MODE_ZP:  state <= ZP_ADDR;
                        MODE_ABS,
                        MODE_JMP: state <= ABS_LO;
                        MODE_ABX,
                        MODE_ABY: state <= IDX_LO;
                        MODE_REL: state <= BR_EVAL;
                    endcase
                end
                IMM_EXEC: begin
                    if (mode == MODE_IMM) pc <= pc_inc;  // Skip operand
                    state <= FETCH;
                end
                ZP_ADDR: begin
                    ea    <= {{(ADDR_W-DATA_W){1'b0}}, din};
                    pc    <= pc_inc;
                    state <= EXEC;
                end
                ABS_LO: begin
                    tr    <= din;
                    pc    <= pc_inc;
                    state <= ABS_HI;
                end
                ABS_HI: begin
                    if (mode == MODE_JMP) begin
                        pc    <= {din, tr};  // Jump taken here
                        state <= FETCH;
                    end else begin
                        ea    <= {din, tr};
                        pc    <= pc_inc;
                        state <= EXEC;
                    end
                end
                IDX_LO: begin
                    tr    <= idx_sum[DATA_W-1:0];
                    carry <= idx_sum[DATA_W];
                    pc    <= pc_inc;
                    state <= IDX_HI;
                end
                IDX_HI: begin
                    ea    <= {din + carry, tr};  // High byte with page carry
                    pc    <= pc_inc;
                    state <= (carry || is_store) ? IDX_FIX : EXEC;
                end
                IDX_FIX: state <= EXEC;
                EXEC: begin
                    wreq  <= is_store;  // Seen high during next FETCH
                    dout  <= store_data;
                    state <= FETCH;
                end
                BR_EVAL: begin
                    if (branch_taken) begin
                        pc    <= br_target;
                        state <= same_page ? BR_SAME : BR_CROSS;
                    end else begin
                        pc    <= pc_inc;
                        state <= FETCH;
                    end
                end
                BR_CROSS: state <= BR_SAME;  // Page cross penalty
                BR_SAME:  state <= FETCH;
                RST_LO: begin
                    tr    <= din;
                    pc    <= pc_inc;
                    state <= RST_HI;
                end
                RST_HI: begin
                    pc    <= {din, tr};
                    state <= FETCH;
                end
                default: state <= RST_LO;
            endcase
        end
    end

    // Checks
    // --------------------
    wreq_single: assert property (@(posedge CLK) disable iff (RESET) wreq |=> !wreq);
    state_legal: assert property (@(posedge CLK) disable iff (RESET)
        state inside {[FETCH:RST_HI]});

endmodule

`default_nettype wire

/* design/cpu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_top import cpu_pkg::*; #(
    parameter logic [ADDR_W-1:0] RESET_VECTOR = 16'hFFFC
) (
    input  logic              CLK,
    input  logic              RESET,
    output logic [ADDR_W-1:0] ADDR,   // Read address
    input  logic [DATA_W-1:0] DIN,    // Combinational read data
    output logic [DATA_W-1:0] DOUT,   // Store data
    output logic [ADDR_W-1:0] EAWR,   // Store address
    output logic              WREQ    // One cycle per store
);

    logic [DATA_W-1:0] opcode;
    addr_mode_t        mode;
    alu_op_t           alu_op;
    reg_sel_t          dst_sel;
    reg_sel_t          src_sel;
    reg_sel_t          index_sel;
    logic              operand_from_reg;
    logic              reg_write;
    logic              flag_write;
    logic              is_store;
    logic              branch_taken;
    logic              exec_strobe;
    logic [DATA_W-1:0] operand_a;
    logic [DATA_W-1:0] operand_b;
    logic [DATA_W-1:0] index;
    logic [DATA_W-1:0] store_data;
    logic [DATA_W-1:0] flags;
    logic [DATA_W-1:0] alu_result;
    logic [DATA_W-1:0] alu_flags;

    cpu_sequencer #(.RESET_VECTOR(RESET_VECTOR)) u_seq (
        .CLK(CLK), .RESET(RESET),
        .din(DIN), .mode(mode), .is_store(is_store), .index(index),
        .store_data(store_data), .branch_taken(branch_taken),
        .opcode(opcode), .exec_strobe(exec_strobe),
        .addr(ADDR), .eawr(EAWR), .dout(DOUT), .wreq(WREQ)
    );

    cpu_decode u_dec (
        .opcode(opcode), .flags(flags),
        .mode(mode), .alu_op(alu_op), .dst_sel(dst_sel), .src_sel(src_sel),
        .operand_from_reg(operand_from_reg), .reg_write(reg_write),
        .flag_write(flag_write), .is_store(is_store), .index_sel(index_sel),
        .branch_taken(branch_taken)
    );

    cpu_regfile u_regs (
        .CLK(CLK), .RESET(RESET), .din(DIN), .exec_strobe(exec_strobe),
        .dst_sel(dst_sel), .src_sel(src_sel), .index_sel(index_sel),
        .operand_from_reg(operand_from_reg), .reg_write(reg_write),
        .flag_write(flag_write), .alu_result(alu_result), .alu_flags(alu_flags),
        .operand_a(operand_a), .operand_b(operand_b), .index(index),
        .store_data(store_data), .flags(flags)
    );

    cpu_alu u_alu (
        .operand_a(operand_a), .operand_b(operand_b), .op(alu_op),
        .flags_in(flags), .result(alu_result), .flags_out(alu_flags)
    );

endmodule

`default_nettype wire

/* list.f */
design/cpu_pkg.sv
design/cpu_decode.sv
design/cpu_alu.sv
design/cpu_regfile.sv
design/cpu_sequencer.sv
design/cpu_top.sv
verification/cpu_tb.sv

/* verification/cpu_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;

    localparam int         PROG_LEN   = 200;                          // Instructions per program
    localparam int         PERIOD     = 20;
    localparam int         TIMEOUT_NS = PROG_LEN * 5 * PERIOD + 4000;  // 5 cycles worst case
    localparam logic [7:0] DATA_PAGE  = 8'h30;                        // Absolute operands

    logic        CLK;
    logic        RESET;
    logic [15:0] ADDR;
    logic [7:0]  DIN;
    logic [7:0]  DOUT;
    logic [15:0] EAWR;
    logic        WREQ;

    logic [7:0]  mem [0:65535];      // Memory seen by the DUT
    logic [7:0]  ref_mem [0:65535];  // Model copy
    logic [7:0]  regs [0:2];         // Model A, X, Y
    logic        fn;
    logic        fv;
    logic        fz;
    logic        fc;
    logic [15:0] pc;                 // Code emit pointer
    logic [15:0] code_start;         // Target of the reset vector
    int          seed;
    int          n_instr;
    logic [15:0] exp_addr [$];       // Expected stores in order
    logic [7:0]  exp_data [$];
    string       exp_name [$];
    int          n_seen;
    int          addr_errors;
    int          data_errors;
    int          other_errors;
    logic        running;            // Out of reset

    cpu_top #(.RESET_VECTOR(16'hFFFC)) UUT (
        .CLK(CLK), .RESET(RESET), .ADDR(ADDR), .DIN(DIN),
        .DOUT(DOUT), .EAWR(EAWR), .WREQ(WREQ)
    );

    // Clock and memory
    // --------------------
    initial CLK = 1'b0;
    always #(PERIOD / 2) CLK = ~CLK;

    assign DIN = $isunknown(ADDR) ? 8'h00 : mem[ADDR];  // Idle bus before reset

    always @(posedge CLK) begin
        if (WREQ === 1'b1) mem[EAWR] <= DOUT;  // Store at the end of the level
    end

    function automatic int rnd(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic int to_signed(input logic [7:0] b);
        return b[7] ? int'(b) - 256 : int'(b);
    endfunction

    function automatic string mode_name(input int mode);
        case (mode)
            1:       return "zp";
            2:       return "abs";
            3:       return "abs_x";
            default: return "abs_y";
        endcase
    endfunction

    // Mode 0 imm, 1 zp, 2 abs, 3 abs_x, 4 abs_y
    // Op is the aaa field
    function automatic logic [7:0] opcode_of(input int op, input int r, input int mode);
        logic [2:0] aaa;
        logic [2:0] bbb;
        aaa = op[2:0];
        if (r == 0) begin
            case (mode)
                0:       bbb = 3'b010;
                1:       bbb = 3'b001;
                2:       bbb = 3'b011;
                3:       bbb = 3'b111;
                default: bbb = 3'b110;
            endcase
            return {aaa, bbb, 2'b01};
        end
        case (mode)
            0:       bbb = 3'b000;
            1:       bbb = 3'b001;
            2:       bbb = 3'b011;
            default: bbb = 3'b111;  // LDX abs,Y and LDY abs,X
        endcase
        if (op == 6) aaa = (r == 1) ? 3'b111 : 3'b110;  // CPX, CPY
        return {aaa, bbb, (r == 1 && op != 6) ? 2'b10 : 2'b00};
    endfunction

    task automatic fill_memory;
        int i;
        for (i = 0; i < 65536; i++) begin
            mem[i]     = i[7:0] ^ {i[11:8], i[15:12]} ^ 8'h5A;
            ref_mem[i] = mem[i];
        end
    endtask

    task automatic emit_byte(input logic [7:0] b);
        mem[pc]     = b;
        ref_mem[pc] = b;
        pc          = pc + 16'd1;
    endtask

    task automatic set_nz(input logic [7:0] r);
        fn = r[7];
        fz = (r == 8'h00);
    endtask

    // Instruction model
    // --------------------
    task automatic exec_alu(input int op, input int r, input logic [7:0] m);
        logic [7:0] acc;
        int         s;
        int         sv;
        acc = regs[r];
        case (op)
            0: acc = acc | m;
            1: acc = acc & m;
            2: acc = acc ^ m;
            3: begin
                s   = int'(acc) + int'(m) + int'(fc);
                sv  = to_signed(acc) + to_signed(m) + int'(fc);
                fc  = (s > 255);
                fv  = (sv > 127) || (sv < -128);  // Signed range left
                acc = s[7:0];
            end
            6: begin
                fc = (acc >= m);  // No borrow
                set_nz(acc - m);
            end
            7: begin
                s   = int'(acc) - int'(m) - int'(!fc);
                sv  = to_signed(acc) - to_signed(m) - int'(!fc);
                fc  = (s >= 0);
                fv  = (sv > 127) || (sv < -128);
                acc = s[7:0];
            end
            default: acc = m;  // Loads
        endcase
        if (op != 6) begin
            regs[r] = acc;
            set_nz(acc);
        end
    endtask

    // Operand bytes of a memory mode with page carry
    task automatic emit_operand(input int mode, output logic [15:0] ea);
        logic [7:0] lo;
        logic [7:0] ofs;
        lo  = 8'(rnd(256));
        ofs = (mode == 3) ? regs[1] : (mode == 4) ? regs[2] : 8'h00;
        emit_byte(lo);
        if (mode == 1) begin
            ea = {8'h00, lo};
        end else begin
            emit_byte(DATA_PAGE);
            ea = {DATA_PAGE, lo} + {8'h00, ofs};
        end
    endtask

    task automatic add_compute(input int op, input int r, input int mode, input logic live);
        logic [15:0] ea;
        logic [7:0]  m;
        emit_byte(opcode_of(op, r, mode));
        if (mode == 0) begin
            m = 8'(rnd(256));
            emit_byte(m);
        end else begin
            emit_operand(mode, ea);
            m = ref_mem[ea];
        end
        if (live) exec_alu(op, r, m);  // Skipped by a taken branch otherwise
        n_instr++;
    endtask

    task automatic add_store(input int r, input int mode, input string tag, input logic live);
        logic [15:0] ea;
        emit_byte(opcode_of(4, r, mode));
        emit_operand(mode, ea);
        if (live) begin
            ref_mem[ea] = regs[r];
            exp_addr.push_back(ea);
            exp_data.push_back(regs[r]);
            exp_name.push_back({tag, "_", mode_name(mode)});
        end
        n_instr++;
    endtask

    // Program generator
    // --------------------
    task automatic build_program;
        logic [15:0] loop_at;
        logic [7:0]  br;
        logic        taken;
        int          kind;
        int          op;
        int          r;
        int          mode;
        pc                = {8'h80 + 8'(rnd(96)), 8'(rnd(256))};  // Random code page
        code_start        = pc;
        mem[16'hFFFC]     = pc[7:0];
        mem[16'hFFFD]     = pc[15:8];
        ref_mem[16'hFFFC] = pc[7:0];
        ref_mem[16'hFFFD] = pc[15:8];
        regs[0] = 8'h00;
        regs[1] = 8'h00;
        regs[2] = 8'h00;
        emit_byte(8'h18);  // CLC
        emit_byte(8'hB8);  // CLV
        fc      = 1'b0;
        fv      = 1'b0;
        n_instr = 2;
        add_compute(5, 0, 0, 1'b1);  // LDA # settles N and Z
        add_store(0, 1, "store", 1'b1);
        while (n_instr < PROG_LEN - 4) begin
            kind = rnd(10);
            if (kind < 5) begin
                op = rnd(7);
                if (op >= 4) op++;  // No STA here
                add_compute(op, 0, rnd(5), 1'b1);
                add_store(0, 1 + rnd(4), "store", 1'b1);
            end else if (kind < 7) begin
                r    = 1 + rnd(2);
                op   = 5 + rnd(2);
                mode = (op == 5) ? rnd(4) : rnd(3);
                if (mode == 3 && r == 1) mode = 4;  // LDX indexes by Y
                add_compute(op, r, mode, 1'b1);
                add_store(r, 1 + rnd(2), "store", 1'b1);
            end else if (kind == 7) begin
                op = rnd(3);
                emit_byte(op == 0 ? 8'h18 : (op == 1 ? 8'h38 : 8'hB8));
                if (op == 0) fc = 1'b0;
                else if (op == 1) fc = 1'b1;
                else fv = 1'b0;
                n_instr++;
            end else begin
                op = rnd(8);
                br = {op[2:1], op[0], 5'b10000};
                case (br[7:6])
                    2'b00:   taken = (fn == br[5]);
                    2'b01:   taken = (fv == br[5]);
                    2'b10:   taken = (fc == br[5]);
                    default: taken = (fz == br[5]);
                endcase
                emit_byte(br);
                emit_byte(8'h02);  // Hop over one 2-byte instruction
                n_instr++;
                op = rnd(7);
                if (op >= 4) op++;
                if (rnd(2) == 0) add_compute(op, 0, 0, !taken);
                else add_store(0, 1, "skipped", !taken);
                add_store(0, 1 + rnd(4), "branch", 1'b1);
            end
        end
        loop_at = pc;
        emit_byte(8'h4C);  // JMP to itself
        emit_byte(loop_at[7:0]);
        emit_byte(loop_at[15:8]);
    endtask

    // Read address in the next cycle, sampled mid-cycle
    task automatic check_addr(input string what, input logic [15:0] expected);
        @(negedge CLK);
        if (ADDR !== expected) begin
            $display("error %s ADDR: expected %h, actual %h", what, expected, ADDR);
            addr_errors++;
        end
    endtask

    // Store monitor sampling where WREQ is steady
    task automatic check_store;
        if (n_seen >= exp_addr.size()) begin
            $display("Unexpected store of %h to %h after the last model store", DOUT, EAWR);
            other_errors++;
        end else begin
            if (EAWR !== exp_addr[n_seen]) begin
                $display("error %s #%0d address: expected %h, actual %h",
                         exp_name[n_seen], n_seen, exp_addr[n_seen], EAWR);
                addr_errors++;
            end
            if (DOUT !== exp_data[n_seen]) begin
                $display("error %s #%0d data: expected %h, actual %h",
                         exp_name[n_seen], n_seen, exp_data[n_seen], DOUT);
                data_errors++;
            end
        end
        n_seen++;
    endtask

    always @(negedge CLK) begin
        if (running) begin
            if (WREQ === 1'b1) begin
                check_store();
            end else if (WREQ !== 1'b0) begin
                $display("WREQ is not a clean level at %0t ns", $time);
                other_errors++;
            end
        end
    end

    // Main sequence
    // --------------------
    initial begin
        seed         = 32'h46d8_6002;
        RESET        = 1'b1;
        running      = 1'b0;
        n_seen       = 0;
        addr_errors  = 0;
        data_errors  = 0;
        other_errors = 0;
        fill_memory();
        build_program();
        repeat (2) @(posedge CLK);
        #2 RESET = 1'b0;
        running = 1'b1;
        check_addr("reset_lo", 16'hFFFC);     // Vector low byte
        check_addr("reset_hi", 16'hFFFD);
        check_addr("first_fetch", code_start);
        wait (n_seen >= exp_addr.size());
        repeat (50) @(posedge CLK);  // JMP loop must stay quiet
        if (n_seen != exp_addr.size()) begin
            $display("Saw %0d stores where the model made %0d", n_seen, exp_addr.size());
            other_errors++;
        end
        $display("Errors: %0d address, %0d data, %0d other",
                 addr_errors, data_errors, other_errors);
        if (addr_errors + data_errors + other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired with %0d of %0d stores seen", n_seen, exp_addr.size());
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire
